/* include/rxdp_fifo_defines.svh */
// RX datapath FIFO sizing macros

`ifndef RXDP_FIFO_DEFINES_SVH
`define RXDP_FIFO_DEFINES_SVH

// **************************************************
// Storage geometry
// **************************************************

// Number of entries, one-hot pointer width
// Must stay even for double-write pairs
`define RXDP_DEPTH 16

// Payload word width
`define RXDP_DWIDTH 40

// Occupancy count width, holds 0..DEPTH
`define RXDP_LWIDTH 5

`endif

/* logic/rxdp_fifo_pkg.sv */
// RX datapath FIFO types

`include "rxdp_fifo_defines.svh"

package rxdp_fifo_pkg;

  // **************************************************
  // Payload and pointer types
  // **************************************************

  typedef logic [`RXDP_DWIDTH-1:0] rx_word_t;   // One FIFO word
  typedef logic [`RXDP_DEPTH-1:0]  rxdp_ptr_t;  // One-hot entry select

  // **************************************************
  // Configuration and status
  // **************************************************

  typedef struct packed {
    logic double_write;  // Two words per accepted write
    logic stop_write;    // Block writes while full
  } rxdp_cfg_t;

  typedef struct packed {
    logic                    full;       // Free space below write step
    logic                    empty;      // No entries held
    logic [`RXDP_LWIDTH-1:0] level;      // Occupancy
    logic                    overflow;   // Sticky, set on overwrite
    logic                    underflow;  // Sticky, set on read while empty
  } rxdp_status_t;

endpackage

/* logic/rxdp_fifo_ram.sv */
// RX datapath FIFO storage array

`timescale 1ns/1ps
`include "rxdp_fifo_defines.svh"

module rxdp_fifo_ram
  import rxdp_fifo_pkg::*;
(
  input  logic      wr_clk,        // Write clock
  input  logic      wr_rst_n,      // Sync reset, active low
  input  logic      wr_push,       // Accepted write this cycle
  input  logic      double_write,  // Also store second word
  input  rxdp_ptr_t wr_ptr,        // One-hot write entry
  input  rx_word_t  wr_data,       // First word
  input  rx_word_t  wr_data2,      // Second word, double mode only
  input  rxdp_ptr_t rd_ptr,        // One-hot head entry
  output rx_word_t  rd_data        // Show-ahead head word
);

  rx_word_t  mem [`RXDP_DEPTH];  // Entry storage
  rxdp_ptr_t wr_ptr_nxt;         // Entry after wr_ptr

  // Next entry, last wraps to first
  assign wr_ptr_nxt = {wr_ptr[`RXDP_DEPTH-2:0], wr_ptr[`RXDP_DEPTH-1]};

  // **************************************************
  // Write port
  // **************************************************
  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      for (int m = 0; m < `RXDP_DEPTH; m++) begin
        mem[m] <= '0;  // Clear all entries
      end
    end else if (wr_push) begin
      for (int m = 0; m < `RXDP_DEPTH; m++) begin
        if (wr_ptr[m]) begin
          mem[m] <= wr_data;  // Primary slot
        end else if (double_write && wr_ptr_nxt[m]) begin
          mem[m] <= wr_data2;  // Paired slot
        end
      end
    end
  end

  // One-hot read mux, OR of selected entry
  always_comb begin
    rd_data = '0;
    for (int i = 0; i < `RXDP_DEPTH; i++) begin
      if (rd_ptr[i]) begin
        rd_data = rd_data | mem[i];
      end
    end
  end

endmodule

/* logic/rxdp_fifo_wr_ctrl.sv */
// RX datapath FIFO write control

`timescale 1ns/1ps
`include "rxdp_fifo_defines.svh"

module rxdp_fifo_wr_ctrl
  import rxdp_fifo_pkg::*;
(
  input  logic       wr_clk,    // Write clock
  input  logic       wr_rst_n,  // Sync reset, active low
  input  rxdp_cfg_t  cfg,       // Mode bits
  input  logic       wr_en,     // Write strobe
  input  logic       full,      // From occupancy tracker
  output rxdp_ptr_t  wr_ptr,    // One-hot write entry
  output logic       wr_push,   // Accepted write
  output logic       wr_over    // Accepted write into full FIFO
);

  rxdp_ptr_t ptr_q;      // Write pointer register
  rxdp_ptr_t ptr_step1;  // Rotated by one
  rxdp_ptr_t ptr_step2;  // Rotated by two

  // **************************************************
  // Acceptance
  // **************************************************

  // Blocked only when full with stop-write on
  assign wr_push = wr_en && (!full || !cfg.stop_write);

  // Overwrite drops oldest words
  assign wr_over = wr_push && full;

  // **************************************************
  // Pointer rotation
  // **************************************************

  assign ptr_step1 = {ptr_q[`RXDP_DEPTH-2:0], ptr_q[`RXDP_DEPTH-1]};
  assign ptr_step2 = {ptr_q[`RXDP_DEPTH-3:0], ptr_q[`RXDP_DEPTH-1:`RXDP_DEPTH-2]};

  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      ptr_q <= rxdp_ptr_t'(1);  // Entry 0
    end else if (wr_push) begin
      // Step of two keeps pairs on even entries
      if (cfg.double_write) begin
        ptr_q <= ptr_step2;
      end else begin
        ptr_q <= ptr_step1;
      end
    end
  end

  assign wr_ptr = ptr_q;

endmodule

/* logic/rxdp_fifo_level.sv */
// RX datapath FIFO occupancy and flags

`timescale 1ns/1ps
`include "rxdp_fifo_defines.svh"

module rxdp_fifo_level
  import rxdp_fifo_pkg::*;
(
  input  logic         wr_clk,    // Write clock
  input  logic         wr_rst_n,  // Sync reset, active low
  input  rxdp_cfg_t    cfg,       // Mode bits
  input  logic         wr_push,   // Accepted write
  input  logic         wr_over,   // Overwrite of oldest words
  input  logic         rd_pop,    // Head word consumed
  input  logic         rd_en,     // Raw read strobe
  output rxdp_status_t status     // Packed status
);

  localparam logic [`RXDP_LWIDTH-1:0] DEPTH_L = `RXDP_DEPTH;  // Capacity

  logic [`RXDP_LWIDTH-1:0] count_q;  // Occupancy
  logic [`RXDP_LWIDTH-1:0] step;     // Words per write
  logic [`RXDP_LWIDTH-1:0] free;     // Unused entries
  logic                    full;
  logic                    empty;
  logic                    ovf_q;    // Sticky overflow
  logic                    udf_q;    // Sticky underflow

  assign step  = cfg.double_write ? `RXDP_LWIDTH'(2) : `RXDP_LWIDTH'(1);
  assign free  = DEPTH_L - count_q;
  assign full  = free < step;          // No room for a whole write
  assign empty = (count_q == '0);

  // **************************************************
  // Occupancy counter
  // **************************************************
  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      count_q <= '0;
    end else if (wr_push && !wr_over) begin
      count_q <= count_q + step - {{(`RXDP_LWIDTH-1){1'b0}}, rd_pop};  // Push, maybe pop
    end else if (rd_pop) begin
      count_q <= count_q - 1'b1;  // Pop only
    end
    // Overwrite leaves count as is
  end

  // Sticky error flags, cleared by reset only
  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      ovf_q <= 1'b0;
      udf_q <= 1'b0;
    end else begin
      if (wr_over)         ovf_q <= 1'b1;
      if (rd_en && empty)  udf_q <= 1'b1;
    end
  end

  assign status = '{full: full, empty: empty, level: count_q,
                    overflow: ovf_q, underflow: udf_q};

endmodule

/* logic/rxdp_fifo_rd_ctrl.sv */
// RX datapath FIFO read control

`timescale 1ns/1ps
`include "rxdp_fifo_defines.svh"

module rxdp_fifo_rd_ctrl
  import rxdp_fifo_pkg::*;
(
  input  logic      wr_clk,    // Write clock
  input  logic      wr_rst_n,  // Sync reset, active low
  input  rxdp_cfg_t cfg,       // Mode bits
  input  logic      rd_en,     // Read strobe
  input  logic      empty,     // From occupancy tracker
  input  logic      wr_over,   // Overwrite this cycle
  output rxdp_ptr_t rd_ptr,    // One-hot head entry
  output logic      rd_pop     // Head word consumed
);

  rxdp_ptr_t ptr_q;      // Read pointer register
  rxdp_ptr_t ptr_step1;  // Rotated by one
  rxdp_ptr_t ptr_step2;  // Rotated by two

  // Overwrite wins over a read in the same cycle
  assign rd_pop = rd_en && !empty && !wr_over;

  assign ptr_step1 = {ptr_q[`RXDP_DEPTH-2:0], ptr_q[`RXDP_DEPTH-1]};
  assign ptr_step2 = {ptr_q[`RXDP_DEPTH-3:0], ptr_q[`RXDP_DEPTH-1:`RXDP_DEPTH-2]};

  // **************************************************
  // Pointer advance
  // **************************************************
  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      ptr_q <= rxdp_ptr_t'(1);  // Entry 0
    end else if (wr_over) begin
      // Drop as many old words as were written
      ptr_q <= cfg.double_write ? ptr_step2 : ptr_step1;
    end else if (rd_pop) begin
      ptr_q <= ptr_step1;  // Normal pop
    end
  end

  assign rd_ptr = ptr_q;

endmodule

/* logic/rxdp_fifo_top.sv */
// RX datapath elastic FIFO, single clock

`timescale 1ns/1ps

module rxdp_fifo_top
  import rxdp_fifo_pkg::*;
(
  input  logic         wr_clk,    // Write clock
  input  logic         wr_rst_n,  // Sync reset, active low
  input  rxdp_cfg_t    cfg,       // Held between tests
  input  logic         wr_en,     // Write strobe
  input  rx_word_t     wr_data,   // First word
  input  rx_word_t     wr_data2,  // Second word
  input  logic         rd_en,     // Read strobe
  output rx_word_t     rd_data,   // Head word
  output rxdp_status_t status     // Levels and sticky flags
);

  rxdp_ptr_t wr_ptr;   // Write entry
  rxdp_ptr_t rd_ptr;   // Head entry
  logic      wr_push;  // Accepted write
  logic      wr_over;  // Overwrite
  logic      rd_pop;   // Pop

  // **************************************************
  // Control and storage
  // **************************************************

  rxdp_fifo_wr_ctrl u_wr_ctrl (
    .wr_clk, .wr_rst_n, .cfg, .wr_en,
    .full    (status.full),
    .wr_ptr, .wr_push, .wr_over
  );

  rxdp_fifo_ram u_ram (
    .wr_clk, .wr_rst_n, .wr_push,
    .double_write (cfg.double_write),
    .wr_ptr, .wr_data, .wr_data2, .rd_ptr, .rd_data
  );

  rxdp_fifo_level u_level (
    .wr_clk, .wr_rst_n, .cfg, .wr_push, .wr_over, .rd_pop, .rd_en, .status
  );

  rxdp_fifo_rd_ctrl u_rd_ctrl (
    .wr_clk, .wr_rst_n, .cfg, .rd_en,
    .empty   (status.empty),
    .wr_over, .rd_ptr, .rd_pop
  );

endmodule

/* verif/rxdp_fifo_clkgen.sv */
// Testbench clock and reset

`timescale 1ns/1ps

module rxdp_fifo_clkgen (
  output logic wr_clk,    // 40 ns write clock
  output logic wr_rst_n   // Sync reset, active low
);

  initial begin
    wr_clk = 1'b0;
    forever #20 wr_clk = ~wr_clk;  // Half period
  end

  initial begin
    wr_rst_n = 1'b0;
    repeat (2) @(posedge wr_clk);  // Two reset edges
    #1 wr_rst_n = 1'b1;            // Release just after the edge
  end

endmodule

/* verif/rxdp_fifo_checker.sv */
// FIFO pointer and flag assertions

`timescale 1ns/1ps
`include "rxdp_fifo_defines.svh"

module rxdp_fifo_checker
  import rxdp_fifo_pkg::*;
(
  input logic         wr_clk,    // Write clock
  input logic         wr_rst_n,  // Active-low sync reset
  input rxdp_cfg_t    cfg,       // Mode bits
  input rxdp_ptr_t    wr_ptr,    // One-hot write entry
  input rxdp_ptr_t    rd_ptr,    // One-hot head entry
  input rxdp_status_t status,    // Flags and level
  input logic         wr_over    // Overwrite strobe
);

  // **************************************************
  // Pointer and flag invariants
  // **************************************************

  a_wr_ptr_onehot: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $onehot(wr_ptr)) else $error("Write pointer is not one-hot");

  a_rd_ptr_onehot: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $onehot(rd_ptr)) else $error("Read pointer is not one-hot");

  a_full_empty: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    !(status.full && status.empty)) else $error("Full and empty both set");

  a_level_max: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    status.level <= `RXDP_LWIDTH'(`RXDP_DEPTH)) else $error("Level above depth");

  // Overwrite only when the level leaves no room for one write
  a_over_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_over |-> (status.level == `RXDP_LWIDTH'(`RXDP_DEPTH) ||
                 (cfg.double_write && status.level == `RXDP_LWIDTH'(`RXDP_DEPTH - 1))))
    else $error("Overwrite while not full");

endmodule

bind rxdp_fifo_top rxdp_fifo_checker u_checker (
  .wr_clk, .wr_rst_n, .cfg, .wr_ptr, .rd_ptr, .status, .wr_over
);

/* verif/rxdp_fifo_tb.sv */
// RX datapath FIFO testbench

`timescale 1ns/1ps
`include "rxdp_fifo_defines.svh"

module rxdp_fifo_tb
  import rxdp_fifo_pkg::*;
();

  typedef struct packed {
    rxdp_cfg_t               cfg;
    logic                    wr_en;
    logic                    rd_en;
    logic                    full;       // Expected after the edge
    logic                    empty;
    logic [`RXDP_LWIDTH-1:0] level;
    logic                    overflow;
    logic                    underflow;
  } row_t;

  localparam rxdp_cfg_t SGL_STOP = '{double_write: 1'b0, stop_write: 1'b1};
  localparam rxdp_cfg_t SGL_OVR  = '{double_write: 1'b0, stop_write: 1'b0};
  localparam rxdp_cfg_t DBL_STOP = '{double_write: 1'b1, stop_write: 1'b1};
  localparam rxdp_cfg_t DBL_OVR  = '{double_write: 1'b1, stop_write: 1'b0};

  logic         wr_clk;
  logic         wr_rst_n;
  rxdp_cfg_t    cfg;
  logic         wr_en;
  rx_word_t     wr_data;
  rx_word_t     wr_data2;
  logic         rd_en;
  rx_word_t     rd_data;
  rxdp_status_t status;

  row_t     rows[$];     // Stimulus table
  rx_word_t model_q[$];  // Reference FIFO contents
  int       errors;
  int       checks;
  bit       built;       // Table ready so watchdog may start

  rxdp_fifo_clkgen u_clkgen (.wr_clk, .wr_rst_n);

  rxdp_fifo_top UUT (
    .wr_clk, .wr_rst_n, .cfg, .wr_en, .wr_data, .wr_data2, .rd_en, .rd_data, .status
  );

  task automatic compare(string what, logic [63:0] got, logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Full when free space is below the write step
  task automatic add_row(rxdp_cfg_t c, logic wr, logic rd, int lvl, logic ovf, logic udf);
    row_t r;
    int   step;
    step = c.double_write ? 2 : 1;
    r = '{cfg: c, wr_en: wr, rd_en: rd, full: (`RXDP_DEPTH - lvl) < step,
          empty: lvl == 0, level: lvl[`RXDP_LWIDTH-1:0], overflow: ovf, underflow: udf};
    rows.push_back(r);
  endtask

  // **************************************************
  // Stimulus table
  // **************************************************
  task automatic build_table();
    add_row(SGL_STOP, 0, 1, 0, 0, 1);                                // Read while empty
    for (int k = 1; k <= 16; k++) add_row(SGL_STOP, 1, 0, k, 0, 1);  // Single fill
    repeat (2) add_row(SGL_STOP, 1, 0, 16, 0, 1);                    // Blocked writes
    for (int k = 15; k >= 0; k--) add_row(SGL_STOP, 0, 1, k, 0, 1);  // Drain in order
    for (int k = 1; k <= 4; k++) add_row(SGL_STOP, 1, 0, k, 0, 1);
    repeat (4) add_row(SGL_STOP, 1, 1, 4, 0, 1);                     // Read and write together
    for (int k = 3; k >= 0; k--) add_row(SGL_STOP, 0, 1, k, 0, 1);
    for (int k = 1; k <= 8; k++) add_row(DBL_STOP, 1, 0, 2 * k, 0, 1);  // Pairs
    add_row(DBL_STOP, 0, 1, 15, 0, 1);                               // Still full at 15
    add_row(DBL_STOP, 1, 0, 15, 0, 1);
    for (int k = 14; k >= 0; k--) add_row(DBL_STOP, 0, 1, k, 0, 1);
    for (int k = 1; k <= 16; k++) add_row(SGL_OVR, 1, 0, k, 0, 1);
    repeat (3) add_row(SGL_OVR, 1, 0, 16, 1, 1);                     // Overwrite oldest
    add_row(SGL_OVR, 1, 1, 16, 1, 1);                                // Read loses to overwrite
    for (int k = 15; k >= 0; k--) add_row(SGL_OVR, 0, 1, k, 1, 1);
    for (int k = 1; k <= 8; k++) add_row(DBL_OVR, 1, 0, 2 * k, 1, 1);
    repeat (2) add_row(DBL_OVR, 1, 0, 16, 1, 1);                     // Drops two per write
    for (int k = 15; k >= 0; k--) add_row(DBL_OVR, 0, 1, k, 1, 1);
  endtask

  // Queue model of one strobe cycle
  task automatic apply_model(rxdp_cfg_t c, logic wr, logic rd, rx_word_t d1, rx_word_t d2);
    int step;
    bit full_m;
    bit push;
    bit over;
    bit pop;
    step   = c.double_write ? 2 : 1;
    full_m = (`RXDP_DEPTH - model_q.size()) < step;
    push   = wr && (!full_m || !c.stop_write);
    over   = push && full_m;
    pop    = rd && (model_q.size() != 0) && !over;
    if (over) begin
      repeat (step) void'(model_q.pop_front());  // Oldest words lost
    end
    if (pop) void'(model_q.pop_front());
    if (push) begin
      model_q.push_back(d1);
      if (c.double_write) model_q.push_back(d2);  // Second word follows the first
    end
  endtask

  task automatic check_row(int idx, row_t r);
    string tag;
    tag = $sformatf("row %0d", idx);
    compare({tag, " full"}, status.full, r.full);
    compare({tag, " empty"}, status.empty, r.empty);
    compare({tag, " level"}, status.level, r.level);
    compare({tag, " overflow"}, status.overflow, r.overflow);
    compare({tag, " underflow"}, status.underflow, r.underflow);
    compare({tag, " level vs model"}, status.level, model_q.size());
    if (model_q.size() != 0) compare({tag, " rd_data"}, rd_data, model_q[0]);
  endtask

  initial begin
    row_t r;
    cfg      = SGL_STOP;
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    wr_data  = '0;
    wr_data2 = '0;
    errors   = 0;
    checks   = 0;
    void'($urandom(32'h4006995f));  // Single seed for the run
    build_table();
    built = 1'b1;
    @(posedge wr_rst_n);
    foreach (rows[i]) begin
      r        = rows[i];
      cfg      = r.cfg;
      wr_en    = r.wr_en;
      rd_en    = r.rd_en;
      wr_data  = rx_word_t'({$urandom(), $urandom()});
      wr_data2 = rx_word_t'({$urandom(), $urandom()});
      apply_model(r.cfg, r.wr_en, r.rd_en, wr_data, wr_data2);
      @(posedge wr_clk);
      #1;  // Registered outputs settled
      check_row(i, r);
    end
    wr_en = 1'b0;
    rd_en = 1'b0;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Watchdog from table length plus margin
  initial begin
    wait (built);
    #((rows.size() + 10) * 40);
    $display("Timeout: FIFO table did not complete in the expected time");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* project.f */
+incdir+include
logic/rxdp_fifo_pkg.sv
logic/rxdp_fifo_ram.sv
logic/rxdp_fifo_wr_ctrl.sv
logic/rxdp_fifo_level.sv
logic/rxdp_fifo_rd_ctrl.sv
logic/rxdp_fifo_top.sv
verif/rxdp_fifo_clkgen.sv
verif/rxdp_fifo_checker.sv
verif/rxdp_fifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the RX datapath FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module rxdp_fifo_tb -o rxdp_fifo_sim > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/rxdp_fifo_sim > sim.log 2>&1

grep -q "=== PASS ===" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
